// File: jtag_bus_req.sv
`timescale 1ns/10ps

module jtag_bus_req
  import jtag_dbg_pkg::*;
(
  input  logic      jtag_tck,
  input  logic      jtag_trst_a,
  input  ir_t       i_ir_latch,
  input  logic      i_run_test_idle,
  input  logic      i_test_logic_reset_nxt,
  input  logic      i_run_test_idle_nxt,
  input  logic      i_select_dr_scan_nxt,
  input  logic      i_capture_dr_nxt,
  input  logic      i_update_dr_nxt,
  output bus_addr_t o_bus_addr,
  output bus_cmd_t  o_bus_cmd,
  output logic      o_bus_req_toggle
);

  bus_addr_t addr_q;
  bus_cmd_t  cmd_q;
  logic      toggle_q;
  logic      wr_ir;
  logic      rd_ir;
  logic      cmd_ir;
  logic      at_reset;

  // register address behind an instruction, status is read only
  function automatic bus_addr_t ir_to_addr(input ir_t ir, input logic rd);
    bus_addr_t addr;
    case (ir)
      IR_ADDRESS: addr = ADDR_ADDRESS;
      IR_DATA:    addr = ADDR_DATA;
      IR_COMMAND: addr = ADDR_COMMAND;
      IR_STATUS:  addr = rd ? ADDR_STATUS : ADDR_RESET;
      default:    addr = ADDR_RESET;
    endcase
    return addr;
  endfunction

  // which instructions actually start a bus cycle
  assign wr_ir  = i_ir_latch inside {IR_ADDRESS, IR_DATA, IR_COMMAND};
  assign rd_ir  = wr_ir || (i_ir_latch == IR_STATUS);
  assign cmd_ir = rd_ir || (i_ir_latch == IR_IDCODE);

  // a registered reset write means the tap already sits in test-logic-reset
  assign at_reset = (cmd_q == CMD_WRITE) && (addr_q == ADDR_RESET);

  // address and command, registered on entry to the state
  // read address is held from select-dr-scan through capture-dr
  always_ff @(posedge jtag_tck or posedge jtag_trst_a)
  begin
    if (jtag_trst_a)
    begin
      cmd_q  <= CMD_NOP;
      addr_q <= ADDR_RESET;
    end
    else if (i_update_dr_nxt)
    begin
      cmd_q  <= CMD_WRITE;
      addr_q <= ir_to_addr(i_ir_latch, 1'b0);
    end
    else if (i_select_dr_scan_nxt || i_capture_dr_nxt)
    begin
      cmd_q  <= CMD_READ;
      addr_q <= ir_to_addr(i_ir_latch, 1'b1);
    end
    else if (i_run_test_idle_nxt)
    begin
      cmd_q  <= CMD_WRITE;
      addr_q <= ADDR_DO_CMD;
    end
    else if (i_test_logic_reset_nxt)
    begin
      cmd_q  <= CMD_WRITE;
      addr_q <= ADDR_RESET;
    end
    else
    begin
      cmd_q  <= CMD_NOP;
      addr_q <= ADDR_RESET;
    end
  end

  // request toggle, each flip is one bus cycle
  // the read is speculative, issued before the host commits to capture-dr
  always_ff @(posedge jtag_tck or posedge jtag_trst_a)
  begin
    if (jtag_trst_a)
      toggle_q <= 1'b0;
    else if (i_update_dr_nxt)
      toggle_q <= toggle_q ^ wr_ir;
    else if (i_select_dr_scan_nxt)
      toggle_q <= toggle_q ^ rd_ir;
    else if (i_run_test_idle_nxt && !i_run_test_idle)
      toggle_q <= toggle_q ^ cmd_ir;
    else if (i_test_logic_reset_nxt && !at_reset)
      toggle_q <= ~toggle_q;
  end

  assign o_bus_addr       = addr_q;
  assign o_bus_cmd        = cmd_q;
  assign o_bus_req_toggle = toggle_q;

  // a request always carries a real command
  a_req_has_cmd: assert property (@(posedge jtag_tck) disable iff (jtag_trst_a)
    $changed(toggle_q) |-> (cmd_q != CMD_NOP));

endmodule

// File: jtag_dbg_pkg.sv
package jtag_dbg_pkg;

  // tap controller states in the usual 1149.1 encoding
  typedef enum logic [3:0] {
    EXIT2_DR         = 4'h0,
    EXIT1_DR         = 4'h1,
    SHIFT_DR         = 4'h2,
    PAUSE_DR         = 4'h3,
    SELECT_IR_SCAN   = 4'h4,
    UPDATE_DR        = 4'h5,
    CAPTURE_DR       = 4'h6,
    SELECT_DR_SCAN   = 4'h7,
    EXIT2_IR         = 4'h8,
    EXIT1_IR         = 4'h9,
    SHIFT_IR         = 4'hA,
    PAUSE_IR         = 4'hB,
    RUN_TEST_IDLE    = 4'hC,
    UPDATE_IR        = 4'hD,
    CAPTURE_IR       = 4'hE,
    TEST_LOGIC_RESET = 4'hF
  } tap_state_t;

  // instruction codes, anything not listed here selects bypass
  typedef logic [3:0] ir_t;
  localparam ir_t IR_EXTEST  = 4'h0;
  localparam ir_t IR_SAMPLE  = 4'h1;
  localparam ir_t IR_STATUS  = 4'h8;
  localparam ir_t IR_COMMAND = 4'h9;
  localparam ir_t IR_ADDRESS = 4'hA;
  localparam ir_t IR_DATA    = 4'hB;
  localparam ir_t IR_IDCODE  = 4'hC;
  localparam ir_t IR_BYPASS  = 4'hF;

  // fixed pattern shifted out of the ir, lets the host spot a broken chain
  localparam ir_t IR_CAPTURE = 4'b0001;

  // data shift register, bus read and write data
  typedef logic [31:0] dr_t;

  // short scan lengths, all other dr instructions use the full 32 bits
  localparam int CMD_LEN    = 4;
  localparam int STATUS_LEN = 6;

  // word address of the debug registers on the far side of the bus
  typedef logic [2:0] bus_addr_t;
  localparam bus_addr_t ADDR_RESET   = 3'd0;
  localparam bus_addr_t ADDR_STATUS  = 3'd1;
  localparam bus_addr_t ADDR_COMMAND = 3'd2;
  localparam bus_addr_t ADDR_ADDRESS = 3'd3;
  localparam bus_addr_t ADDR_DATA    = 3'd4;
  localparam bus_addr_t ADDR_DO_CMD  = 3'd5;

  // bus command
  typedef enum logic [1:0] {
    CMD_NOP   = 2'b00,
    CMD_READ  = 2'b01,
    CMD_WRITE = 2'b10
  } bus_cmd_t;

endpackage

// File: jtag_debug_port.sv
`timescale 1ns/10ps

module jtag_debug_port
  import jtag_dbg_pkg::*;
#(
  parameter dr_t IDCODE_VALUE = 32'h0000_0001
)
(
  input  logic      jtag_tck,
  input  logic      jtag_trst_a,
  input  logic      i_tms,
  input  logic      i_tdi,
  input  dr_t       i_bus_rdata,
  output logic      o_tdo,
  output logic      o_busy,
  output bus_addr_t o_bus_addr,
  output bus_cmd_t  o_bus_cmd,
  output dr_t       o_bus_wdata,
  output logic      o_bus_req_toggle
);

  // current state decodes
  logic test_logic_reset;
  logic run_test_idle;
  logic capture_ir;
  logic shift_ir;
  logic update_ir;
  logic capture_dr;
  logic shift_dr;
  logic select_ir;
  // next state decodes
  logic test_logic_reset_nxt;
  logic run_test_idle_nxt;
  logic select_dr_scan_nxt;
  logic capture_dr_nxt;
  logic update_dr_nxt;
  ir_t  ir_latch;

  // tap controller
  jtag_tap_fsm u_tap_fsm (
    .jtag_tck               (jtag_tck),
    .jtag_trst_a            (jtag_trst_a),
    .i_tms                  (i_tms),
    .o_test_logic_reset     (test_logic_reset),
    .o_run_test_idle        (run_test_idle),
    .o_capture_ir           (capture_ir),
    .o_shift_ir             (shift_ir),
    .o_update_ir            (update_ir),
    .o_capture_dr           (capture_dr),
    .o_shift_dr             (shift_dr),
    .o_select_ir            (select_ir),
    .o_test_logic_reset_nxt (test_logic_reset_nxt),
    .o_run_test_idle_nxt    (run_test_idle_nxt),
    .o_select_dr_scan_nxt   (select_dr_scan_nxt),
    .o_capture_dr_nxt       (capture_dr_nxt),
    .o_update_dr_nxt        (update_dr_nxt)
  );

  // ir, dr, bypass and tdo, the shift register doubles as bus write data
  jtag_scan_regs #(
    .IDCODE_VALUE (IDCODE_VALUE)
  ) u_scan_regs (
    .jtag_tck           (jtag_tck),
    .jtag_trst_a        (jtag_trst_a),
    .i_tdi              (i_tdi),
    .i_test_logic_reset (test_logic_reset),
    .i_run_test_idle    (run_test_idle),
    .i_capture_ir       (capture_ir),
    .i_shift_ir         (shift_ir),
    .i_update_ir        (update_ir),
    .i_capture_dr       (capture_dr),
    .i_shift_dr         (shift_dr),
    .i_select_ir        (select_ir),
    .i_bus_rdata        (i_bus_rdata),
    .o_ir_latch         (ir_latch),
    .o_shift_data       (o_bus_wdata),
    .o_tdo              (o_tdo)
  );

  // bus address, command and request toggle
  jtag_bus_req u_bus_req (
    .jtag_tck               (jtag_tck),
    .jtag_trst_a            (jtag_trst_a),
    .i_ir_latch             (ir_latch),
    .i_run_test_idle        (run_test_idle),
    .i_test_logic_reset_nxt (test_logic_reset_nxt),
    .i_run_test_idle_nxt    (run_test_idle_nxt),
    .i_select_dr_scan_nxt   (select_dr_scan_nxt),
    .i_capture_dr_nxt       (capture_dr_nxt),
    .i_update_dr_nxt        (update_dr_nxt),
    .o_bus_addr             (o_bus_addr),
    .o_bus_cmd              (o_bus_cmd),
    .o_bus_req_toggle       (o_bus_req_toggle)
  );

  // busy whenever the host is doing anything but resting, e.g. for an activity led
  assign o_busy = ~(test_logic_reset | run_test_idle);

endmodule

// File: jtag_scan_regs.sv
`timescale 1ns/10ps

module jtag_scan_regs
  import jtag_dbg_pkg::*;
#(
  parameter dr_t IDCODE_VALUE = 32'h0000_0001
)
(
  input  logic jtag_tck,
  input  logic jtag_trst_a,
  input  logic i_tdi,
  input  logic i_test_logic_reset,
  input  logic i_run_test_idle,
  input  logic i_capture_ir,
  input  logic i_shift_ir,
  input  logic i_update_ir,
  input  logic i_capture_dr,
  input  logic i_shift_dr,
  input  logic i_select_ir,
  input  dr_t  i_bus_rdata,
  output ir_t  o_ir_latch,
  output dr_t  o_shift_data,
  output logic o_tdo
);

  ir_t  ir_sreg_q;
  ir_t  ir_latch_q;
  dr_t  shift_q;
  logic bypass_q;
  logic tdo_q;
  logic dr_sel;
  logic dr_tdo;

  // instructions that own the data shift register
  // all other codes use bypass
  assign dr_sel = ir_latch_q inside {IR_STATUS, IR_COMMAND, IR_ADDRESS, IR_DATA, IR_IDCODE};
  assign dr_tdo = dr_sel ? shift_q[0] : bypass_q;

  // ir shift register
  // lsb leaves first and tdi enters at the top
  always_ff @(posedge jtag_tck)
  begin
    if (i_capture_ir)
      ir_sreg_q <= IR_CAPTURE;
    else if (i_shift_ir)
      ir_sreg_q <= {i_tdi, ir_sreg_q[3:1]};
  end

  // instruction latch
  // idcode is the power-up and reset instruction
  always_ff @(posedge jtag_tck or posedge jtag_trst_a)
  begin
    if (jtag_trst_a)
      ir_latch_q <= IR_IDCODE;
    else if (i_test_logic_reset)
      ir_latch_q <= IR_IDCODE;
    else if (i_update_ir)
      ir_latch_q <= ir_sreg_q;
  end

  // data shift register
  // scan length follows the instruction and tdi goes in at the top used bit
  always_ff @(posedge jtag_tck)
  begin
    if (i_test_logic_reset)
      shift_q <= '0;
    else if (i_shift_dr)
    begin
      case (ir_latch_q)
        IR_COMMAND: shift_q[CMD_LEN-1:0]    <= {i_tdi, shift_q[CMD_LEN-1:1]};
        IR_STATUS:  shift_q[STATUS_LEN-1:0] <= {i_tdi, shift_q[STATUS_LEN-1:1]};
        default:    shift_q                 <= {i_tdi, shift_q[31:1]};
      endcase
    end
    else if (i_capture_dr)
    begin
      case (ir_latch_q)
        IR_ADDRESS, IR_DATA: shift_q <= i_bus_rdata;
        // short registers come back zero extended
        IR_COMMAND:          shift_q <= dr_t'(i_bus_rdata[CMD_LEN-1:0]);
        IR_STATUS:           shift_q <= dr_t'(i_bus_rdata[STATUS_LEN-1:0]);
        IR_IDCODE:           shift_q <= IDCODE_VALUE;
        // boundary scan codes have no chain here and behave as bypass
        default:             shift_q <= '0;
      endcase
    end
  end

  // one bit bypass path
  // zero on capture then tdi delayed by a clock
  always_ff @(posedge jtag_tck)
  begin
    if (i_capture_dr)
      bypass_q <= 1'b0;
    else if (i_shift_dr)
      bypass_q <= i_tdi;
  end

  // tdo changes on the falling edge so the host sees it settled at the next rise
  // held low while the port is idle
  always_ff @(negedge jtag_tck or posedge jtag_trst_a)
  begin
    if (jtag_trst_a)
      tdo_q <= 1'b0;
    else if (i_test_logic_reset || i_run_test_idle)
      tdo_q <= 1'b0;
    else if (i_shift_dr || i_shift_ir)
      tdo_q <= i_select_ir ? ir_sreg_q[0] : dr_tdo;
  end

  assign o_ir_latch   = ir_latch_q;
  assign o_shift_data = shift_q;
  assign o_tdo        = tdo_q;

  // the fsm can only be in one shift state, and ir shifting lies in the ir column
  a_one_shift: assert property (@(posedge jtag_tck) disable iff (jtag_trst_a)
    !(i_shift_ir && i_shift_dr) && (!i_shift_ir || i_select_ir));

endmodule

// File: jtag_tap_fsm.sv
`timescale 1ns/10ps

module jtag_tap_fsm
  import jtag_dbg_pkg::*;
(
  input  logic jtag_tck,
  input  logic jtag_trst_a,
  input  logic i_tms,
  output logic o_test_logic_reset,
  output logic o_run_test_idle,
  output logic o_capture_ir,
  output logic o_shift_ir,
  output logic o_update_ir,
  output logic o_capture_dr,
  output logic o_shift_dr,
  output logic o_select_ir,
  output logic o_test_logic_reset_nxt,
  output logic o_run_test_idle_nxt,
  output logic o_select_dr_scan_nxt,
  output logic o_capture_dr_nxt,
  output logic o_update_dr_nxt
);

  tap_state_t state_q;
  tap_state_t state_nxt;

  // standard 1149.1 transitions, tms picks one of two successors
  always_comb
  begin
    case (state_q)
      TEST_LOGIC_RESET: state_nxt = i_tms ? TEST_LOGIC_RESET : RUN_TEST_IDLE;
      RUN_TEST_IDLE:    state_nxt = i_tms ? SELECT_DR_SCAN   : RUN_TEST_IDLE;
      // dr column
      SELECT_DR_SCAN:   state_nxt = i_tms ? SELECT_IR_SCAN   : CAPTURE_DR;
      CAPTURE_DR:       state_nxt = i_tms ? EXIT1_DR         : SHIFT_DR;
      SHIFT_DR:         state_nxt = i_tms ? EXIT1_DR         : SHIFT_DR;
      EXIT1_DR:         state_nxt = i_tms ? UPDATE_DR        : PAUSE_DR;
      PAUSE_DR:         state_nxt = i_tms ? EXIT2_DR         : PAUSE_DR;
      EXIT2_DR:         state_nxt = i_tms ? UPDATE_DR        : SHIFT_DR;
      UPDATE_DR:        state_nxt = i_tms ? SELECT_DR_SCAN   : RUN_TEST_IDLE;
      // ir column
      SELECT_IR_SCAN:   state_nxt = i_tms ? TEST_LOGIC_RESET : CAPTURE_IR;
      CAPTURE_IR:       state_nxt = i_tms ? EXIT1_IR         : SHIFT_IR;
      SHIFT_IR:         state_nxt = i_tms ? EXIT1_IR         : SHIFT_IR;
      EXIT1_IR:         state_nxt = i_tms ? UPDATE_IR        : PAUSE_IR;
      PAUSE_IR:         state_nxt = i_tms ? EXIT2_IR         : PAUSE_IR;
      EXIT2_IR:         state_nxt = i_tms ? UPDATE_IR        : SHIFT_IR;
      UPDATE_IR:        state_nxt = i_tms ? SELECT_DR_SCAN   : RUN_TEST_IDLE;
      // unknown state falls back to reset
      default:          state_nxt = TEST_LOGIC_RESET;
    endcase
  end

  // trst puts the port in test-logic-reset
  always_ff @(posedge jtag_tck or posedge jtag_trst_a)
  begin
    if (jtag_trst_a)
      state_q <= TEST_LOGIC_RESET;
    else
      state_q <= state_nxt;
  end

  // current state decodes
  assign o_test_logic_reset = (state_q == TEST_LOGIC_RESET);
  assign o_run_test_idle    = (state_q == RUN_TEST_IDLE);
  assign o_capture_ir       = (state_q == CAPTURE_IR);
  assign o_shift_ir         = (state_q == SHIFT_IR);
  assign o_update_ir        = (state_q == UPDATE_IR);
  assign o_capture_dr       = (state_q == CAPTURE_DR);
  assign o_shift_dr         = (state_q == SHIFT_DR);

  // whole ir column, steers tdo to the instruction register
  assign o_select_ir = state_q inside {SELECT_IR_SCAN, CAPTURE_IR, SHIFT_IR, EXIT1_IR,
                                       PAUSE_IR, EXIT2_IR, UPDATE_IR};

  // next state decodes, bus requests register on these
  assign o_test_logic_reset_nxt = (state_nxt == TEST_LOGIC_RESET);
  assign o_run_test_idle_nxt    = (state_nxt == RUN_TEST_IDLE);
  assign o_select_dr_scan_nxt   = (state_nxt == SELECT_DR_SCAN);
  assign o_capture_dr_nxt       = (state_nxt == CAPTURE_DR);
  assign o_update_dr_nxt        = (state_nxt == UPDATE_DR);

  // state register must never pick up x from tms
  a_state_known: assert property (@(posedge jtag_tck) disable iff (jtag_trst_a)
    !$isunknown(state_q));

  // five tms highs reach test-logic-reset from any state
  a_tms_reset: assert property (@(posedge jtag_tck) disable iff (jtag_trst_a)
    i_tms [*5] |=> (state_q == TEST_LOGIC_RESET));

endmodule

// File: list.f
+incdir+.
jtag_dbg_pkg.sv
jtag_tap_fsm.sv
jtag_scan_regs.sv
jtag_bus_req.sv
jtag_debug_port.sv
tb_jtag_debug_port.sv

// File: tb_jtag_tasks.svh
// one tck period
// inputs change here on the falling edge and tdo is taken at the next rise
task automatic clock_bit(input logic tms, input logic tdi, output logic tdo);
  i_tms = tms;
  i_tdi = tdi;
  @(posedge jtag_tck);
  tdo = o_tdo;
  @(negedge jtag_tck);
endtask

// walk the tap with a tms string
// lsb first with tdi held low
task automatic tms_walk(input int n, input logic [7:0] seq);
  logic unused;
  for (int i = 0; i < n; i++)
    clock_bit(seq[i], 1'b0, unused);
endtask

// shift n bits from a shift state
// the last bit leaves with tms high
task automatic shift_bits(input int n, input dr_t din, output dr_t dout);
  logic bit_out;
  dout = '0;
  for (int i = 0; i < n; i++)
  begin
    clock_bit(i == n - 1, din[i], bit_out);
    dout[i] = bit_out;
  end
  // update, idle and one extra idle clock so the bus log has settled
  tms_walk(3, 8'b001);
endtask

// idle to shift-ir through both select states
task automatic ir_scan(input ir_t ir, output dr_t dout);
  tms_walk(4, 8'b0011);
  shift_bits(4, dr_t'(ir), dout);
endtask

// idle to shift-dr
task automatic dr_scan(input int n, input dr_t din, output dr_t dout);
  tms_walk(3, 8'b001);
  check_value("busy in shift-dr", o_busy, 1'b1);
  shift_bits(n, din, dout);
endtask

task automatic check_value(input string what, input dr_t got, input dr_t exp);
  checks++;
  if (got !== exp)
  begin
    errors++;
    $display("ERROR %0t ns: %s is %h, expected %h", $time, what, got, exp);
  end
endtask

// one logged bus request
// write data only compared when asked for
task automatic check_log(input int idx, input bus_cmd_t cmd, input bus_addr_t addr,
                         input logic chk_data, input dr_t data);
  if (idx >= log_cmd.size())
  begin
    errors++;
    $display("ERROR %0t ns: bus log has no request number %0d", $time, idx);
  end
  else
  begin
    check_value("bus command", log_cmd[idx], cmd);
    check_value("bus address", log_addr[idx], addr);
    if (chk_data)
      check_value("bus write data", log_data[idx], data);
  end
endtask

// 13/17/5 xorshift
function automatic dr_t xorshift32(input dr_t x);
  dr_t y;
  y = x ^ (x << 13);
  y = y ^ (y >> 17);
  y = y ^ (y << 5);
  return y;
endfunction

function automatic dr_t next_random();
  rng_state = xorshift32(rng_state);
  return rng_state;
endfunction

// File: tb_jtag_debug_port.sv
`timescale 1ns/10ps

module tb_jtag_debug_port
  import jtag_dbg_pkg::*;
();

  localparam dr_t IDCODE         = 32'h1357_9BDF;
  localparam int  TIMEOUT_CYCLES = 3000;

  logic      jtag_tck    = 1'b0;
  logic      jtag_trst_a = 1'b1;
  logic      i_tms       = 1'b1;
  logic      i_tdi       = 1'b0;
  dr_t       i_bus_rdata;
  logic      o_tdo;
  logic      o_busy;
  bus_addr_t o_bus_addr;
  bus_cmd_t  o_bus_cmd;
  dr_t       o_bus_wdata;
  logic      o_bus_req_toggle;

  // bus model registers, status up to data
  dr_t       dbg_regs [ADDR_STATUS:ADDR_DATA];
  bus_cmd_t  log_cmd[$];
  bus_addr_t log_addr[$];
  dr_t       log_data[$];
  logic      toggle_seen = 1'b0;
  dr_t       rng_state   = 32'd97158;
  int        checks      = 0;
  int        errors      = 0;
  int        cycles      = 0;

  `include "tb_jtag_tasks.svh"

  always #50 jtag_tck = ~jtag_tck;

  jtag_debug_port #(
    .IDCODE_VALUE (IDCODE)
  ) dut (
    .jtag_tck         (jtag_tck),
    .jtag_trst_a      (jtag_trst_a),
    .i_tms            (i_tms),
    .i_tdi            (i_tdi),
    .i_bus_rdata      (i_bus_rdata),
    .o_tdo            (o_tdo),
    .o_busy           (o_busy),
    .o_bus_addr       (o_bus_addr),
    .o_bus_cmd        (o_bus_cmd),
    .o_bus_wdata      (o_bus_wdata),
    .o_bus_req_toggle (o_bus_req_toggle)
  );

  // fill differs for every address
  initial
  begin
    for (int a = ADDR_STATUS; a <= ADDR_DATA; a++)
      dbg_regs[a] = 32'hC3A5_0000 ^ (a * 32'h0001_1111);
  end

  // read data follows the address with no delay
  assign i_bus_rdata = (o_bus_addr >= ADDR_STATUS && o_bus_addr <= ADDR_DATA) ?
                       dbg_regs[o_bus_addr] : '0;

  // one log entry per toggle flip
  // taken at the falling edge, half a clock after the request registers
  always @(negedge jtag_tck)
  begin
    if (o_bus_req_toggle !== toggle_seen)
    begin
      toggle_seen = o_bus_req_toggle;
      log_cmd.push_back(o_bus_cmd);
      log_addr.push_back(o_bus_addr);
      log_data.push_back(o_bus_wdata);
      if (o_bus_cmd == CMD_WRITE && o_bus_addr >= ADDR_STATUS && o_bus_addr <= ADDR_DATA)
        dbg_regs[o_bus_addr] = o_bus_wdata;
    end
  end

  always @(posedge jtag_tck)
  begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES)
    begin
      $display("timeout, the tests were still running after %0d clock cycles", cycles);
      $display("Test failed");
      $finish;
    end
  end

  // reset write on the first clock, then a do-command write on idle entry
  task automatic idcode_after_reset();
    dr_t out;
    tms_walk(1, 8'b1);
    check_value("busy in test-logic-reset", o_busy, 1'b0);
    tms_walk(2, 8'b00);
    check_value("requests after reset", log_cmd.size(), 2);
    check_log(0, CMD_WRITE, ADDR_RESET, 1'b0, '0);
    check_log(1, CMD_WRITE, ADDR_DO_CMD, 1'b0, '0);
    dr_scan(32, next_random(), out);
    check_value("idcode", out, IDCODE);
  endtask

  // one bit delay with a leading zero and no bus traffic
  task automatic bypass_path();
    dr_t out;
    dr_t din;
    int  n_req;
    ir_scan(IR_BYPASS, out);
    check_value("ir capture pattern", out, IR_CAPTURE);
    n_req = log_cmd.size();
    din = next_random();
    dr_scan(32, din, out);
    check_value("bypass data", out, {din[30:0], 1'b0});
    check_value("requests in bypass", log_cmd.size(), n_req);
  endtask

  task automatic address_write();
    dr_t out;
    dr_t din;
    dr_t prior;
    int  n_req;
    ir_scan(IR_ADDRESS, out);
    prior = dbg_regs[ADDR_ADDRESS];
    n_req = log_cmd.size();
    din = next_random();
    dr_scan(32, din, out);
    check_value("address read back", out, prior);
    // speculative read at select-dr-scan, write at update-dr
    check_log(n_req, CMD_READ, ADDR_ADDRESS, 1'b0, '0);
    check_log(n_req + 1, CMD_WRITE, ADDR_ADDRESS, 1'b1, din);
  endtask

  task automatic status_read();
    dr_t out;
    dr_t status;
    status = next_random();
    dbg_regs[ADDR_STATUS] = status;
    ir_scan(IR_STATUS, out);
    dr_scan(STATUS_LEN, '0, out);
    check_value("status", out, status & ((32'd1 << STATUS_LEN) - 1));
  endtask

  // short register, upper write data bits stay zero
  task automatic command_write();
    dr_t out;
    dr_t din;
    dr_t prior;
    int  n_req;
    din = next_random() & ((32'd1 << CMD_LEN) - 1);
    prior = dbg_regs[ADDR_COMMAND];
    ir_scan(IR_COMMAND, out);
    n_req = log_cmd.size();
    dr_scan(CMD_LEN, din, out);
    check_value("command read back", out, prior & ((32'd1 << CMD_LEN) - 1));
    check_log(n_req, CMD_READ, ADDR_COMMAND, 1'b0, '0);
    check_log(n_req + 1, CMD_WRITE, ADDR_COMMAND, 1'b1, din);
    check_log(n_req + 2, CMD_WRITE, ADDR_DO_CMD, 1'b0, '0);
  endtask

  // select-dr read, then the reset write when the tap reaches test-logic-reset
  task automatic tms_reset();
    dr_t out;
    int  n_req;
    n_req = log_cmd.size();
    tms_walk(5, 8'b1_1111);
    check_log(n_req + 1, CMD_WRITE, ADDR_RESET, 1'b0, '0);
    check_value("busy after tms reset", o_busy, 1'b0);
    tms_walk(2, 8'b00);
    dr_scan(32, next_random(), out);
    check_value("idcode after tms reset", out, IDCODE);
  endtask

  initial
  begin
    repeat (4) @(negedge jtag_tck);
    jtag_trst_a = 1'b0;
    idcode_after_reset();
    bypass_path();
    address_write();
    status_read();
    command_write();
    tms_reset();
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("Test completed successfully");
    else
      $display("Test failed");
    $finish;
  end

endmodule
